//--- hdl/seg_defines.svh
/* build-time sizes for the seven-segment scan driver:
   digit count, slot and count dividers, startup hold length */
`ifndef SEG_DEFINES_SVH
`define SEG_DEFINES_SVH

// number of digits on the display, one anode each
`define SEG_DIGITS 4

// clocks per segment slot, kept short for simulation
`define DOT_DIV 4

// full scan frames per counter step
`define FRAMES_PER_COUNT 2

// clocks the display stays dark after reset
`define STARTUP_CYCLES 20

`endif

//--- hdl/seg_pkg.sv
/* shared types of the scan driver: controller state, segment slot codes,
   segment pattern, decimal count, scan position and controller strobes */
`include "seg_defines.svh"

package seg_pkg;

	localparam int DIGIT_W = (`SEG_DIGITS > 1) ? $clog2(`SEG_DIGITS) : 1; // digit index width

	typedef enum logic {
		ST_STARTUP, // display held dark
		ST_RUN      // scanning
	} ctrl_state_e;

	// one slot per segment, then a dark slot before the next digit
	typedef enum logic [2:0] {
		SLOT_A     = 3'd0,
		SLOT_B     = 3'd1,
		SLOT_C     = 3'd2,
		SLOT_D     = 3'd3,
		SLOT_E     = 3'd4,
		SLOT_F     = 3'd5,
		SLOT_G     = 3'd6,
		SLOT_BLANK = 3'd7
	} slot_e;

	typedef struct packed {
		logic a; // msb, 0 lights the segment
		logic b;
		logic c;
		logic d;
		logic e;
		logic f;
		logic g; // lsb
	} seg_pattern_t;

	typedef logic [`SEG_DIGITS-1:0][3:0] bcd_count_t; // [0] least significant digit

	typedef logic [DIGIT_W-1:0] digit_idx_t;

	typedef struct packed {
		digit_idx_t digit; // anode being driven
		slot_e      slot;  // segment being driven
	} scan_pos_t;

	typedef struct packed {
		logic slot_tick;  // step scanner one slot
		logic count_tick; // step decimal counter
	} scan_strobe_t;

endpackage

//--- hdl/scan_ctrl.sv
/* scan controller: startup hold FSM, segment slot prescaler,
   frame counter that gates the count strobe with run */
`timescale 1ns/1ps
`include "seg_defines.svh"

module scan_ctrl (
	input  logic                  CLK,
	input  logic                  reset,
	input  logic                  frame_start,
	input  logic                  run,
	output seg_pkg::scan_strobe_t strobe,
	output logic                  ready
);
	import seg_pkg::*;

	localparam int HOLD_W  = $clog2(`STARTUP_CYCLES + 1);
	localparam int DIV_W   = (`DOT_DIV > 1) ? $clog2(`DOT_DIV) : 1;
	localparam int FRAME_W = (`FRAMES_PER_COUNT > 1) ? $clog2(`FRAMES_PER_COUNT) : 1;

	ctrl_state_e        state;
	logic [HOLD_W-1:0]  hold_cnt;   // clocks spent in startup
	logic [DIV_W-1:0]   div_cnt;    // slot prescaler
	logic [FRAME_W-1:0] frame_cnt;  // frames since last count step
	logic               div_wrap;   // last clock of a slot
	logic               frame_last; // next frame_start completes a count period

	assign div_wrap   = (div_cnt == DIV_W'(`DOT_DIV - 1));
	assign frame_last = (frame_cnt == FRAME_W'(`FRAMES_PER_COUNT - 1));
	assign ready      = (state == ST_RUN);

	// ready rises STARTUP_CYCLES clocks after the first edge out of reset
	always_ff @(posedge CLK) begin
		if (reset) begin
			state    <= ST_STARTUP;
			hold_cnt <= '0;
		end else begin
			case (state)
				ST_STARTUP: begin
					if (hold_cnt == HOLD_W'(`STARTUP_CYCLES)) begin
						state <= ST_RUN; // hold done, start scanning
					end else begin
						hold_cnt <= hold_cnt + 1'b1;
					end
				end
				default: begin
					state <= ST_RUN; // stays here until reset
				end
			endcase
		end
	end

	// strobes are single-clock pulses, idle unless set below
	always_ff @(posedge CLK) begin
		if (reset) begin
			div_cnt   <= '0;
			frame_cnt <= '0;
			strobe    <= '0;
		end else begin
			strobe <= '0;
			if (state == ST_RUN) begin
				div_cnt          <= div_wrap ? '0 : div_cnt + 1'b1;
				strobe.slot_tick <= div_wrap; // once every DOT_DIV clocks
				if (frame_start) begin
					frame_cnt         <= frame_last ? '0 : frame_cnt + 1'b1; // counts with run low too
					strobe.count_tick <= frame_last & run; // only the counter step is gated
				end
			end
		end
	end

endmodule

//--- hdl/digit_counter.sv
/* decimal up counter of SEG_DIGITS digits, carry rippling from digit 0,
   synchronous clear taking priority over the count strobe */
`timescale 1ns/1ps
`include "seg_defines.svh"

module digit_counter (
	input  logic                CLK,
	input  logic                reset,
	input  logic                clear,
	input  logic                count_tick,
	output seg_pkg::bcd_count_t count
);
	import seg_pkg::*;

	bcd_count_t count_next; // count plus one, in decimal

	// a step enters digit 0 and carries up while digits roll over from 9
	always_comb begin
		logic carry;
		carry = 1'b1;
		for (int i = 0; i < `SEG_DIGITS; i++) begin
			count_next[i] = count[i];
			if (carry) begin
				if (count[i] >= 4'd9) begin
					count_next[i] = 4'd0; // roll over, carry stays set
				end else begin
					count_next[i] = count[i] + 4'd1;
					carry         = 1'b0; // absorbed here
				end
			end
		end
	end

	// all nines wrap to all zeros through the carry chain
	always_ff @(posedge CLK) begin
		if (reset) begin
			count <= '0;
		end else if (clear) begin
			count <= '0; // clear beats a coincident tick
		end else if (count_tick) begin
			count <= count_next;
		end
	end

endmodule

//--- hdl/seg_decoder.sv
/* frame snapshot of the decimal count and lookup of the
   active-low segment pattern for the digit under the scan */
`timescale 1ns/1ps
`include "seg_defines.svh"

module seg_decoder (
	input  logic                  CLK,
	input  logic                  reset,
	input  logic                  frame_start,
	input  seg_pkg::bcd_count_t   count,
	input  seg_pkg::scan_pos_t    pos,
	output seg_pkg::seg_pattern_t pattern
);
	import seg_pkg::*;

	bcd_count_t snap;      // count as shown for the current frame
	bcd_count_t shown;     // snapshot, or live count on the frame's first clock
	logic [3:0] digit_val; // value of the scanned digit

	always_ff @(posedge CLK) begin
		if (reset) begin
			snap <= '0;
		end else if (frame_start) begin
			snap <= count;
		end
	end

	// frame_start coincides with digit 0 slot a, so that clock already sees the new value
	assign shown     = frame_start ? count : snap;
	assign digit_val = shown[pos.digit];

	// bit order a..g, 0 lights the segment
	always_comb begin
		case (digit_val)
			4'd0:    pattern = 7'b0000001;
			4'd1:    pattern = 7'b1001111;
			4'd2:    pattern = 7'b0010010;
			4'd3:    pattern = 7'b0000110;
			4'd4:    pattern = 7'b1001100;
			4'd5:    pattern = 7'b0100100;
			4'd6:    pattern = 7'b0100000;
			4'd7:    pattern = 7'b0001111;
			4'd8:    pattern = 7'b0000000;
			4'd9:    pattern = 7'b0000100;
			default: pattern = 7'b1111111; // not decimal, keep dark
		endcase
		if (pos.slot == SLOT_BLANK) begin
			pattern = 7'b1111111; // gap slot between digits
		end
	end

endmodule

//--- hdl/segment_scanner.sv
/* scan position walker over slots and digits, frame start pulse,
   registered single-segment and one-hot anode drive */
`timescale 1ns/1ps
`include "seg_defines.svh"

module segment_scanner (
	input  logic                   CLK,
	input  logic                   reset,
	input  logic                   ready,
	input  logic                   slot_tick,
	input  seg_pkg::seg_pattern_t  pattern,
	output seg_pkg::scan_pos_t     pos,
	output logic                   frame_start,
	output seg_pkg::seg_pattern_t  seg,
	output logic [`SEG_DIGITS-1:0] anode
);
	import seg_pkg::*;

	localparam digit_idx_t LAST_DIGIT = digit_idx_t'(`SEG_DIGITS - 1);

	seg_pattern_t           seg_next;   // only the current slot's bit may be 0
	logic [`SEG_DIGITS-1:0] anode_next;
	logic                   wrap;       // blank slot of the last digit

	assign wrap = (pos.slot == SLOT_BLANK) && (pos.digit == LAST_DIGIT);

	// a..g then blank, then the next digit, digit 0 first
	always_ff @(posedge CLK) begin
		if (reset) begin
			pos.digit   <= '0;
			pos.slot    <= SLOT_A;
			frame_start <= 1'b0;
		end else begin
			frame_start <= 1'b0;
			if (ready && slot_tick) begin
				frame_start <= wrap; // high while pos sits at digit 0, slot a
				if (pos.slot == SLOT_BLANK) begin
					pos.slot  <= SLOT_A;
					pos.digit <= wrap ? '0 : pos.digit + 1'b1;
				end else begin
					pos.slot <= slot_e'(pos.slot + 3'd1);
				end
			end
		end
	end

	always_comb begin
		seg_next   = '1;
		anode_next = '0;
		anode_next[pos.digit] = 1'b1; // held through the blank slot as well
		case (pos.slot)
			SLOT_A:  seg_next.a = pattern.a;
			SLOT_B:  seg_next.b = pattern.b;
			SLOT_C:  seg_next.c = pattern.c;
			SLOT_D:  seg_next.d = pattern.d;
			SLOT_E:  seg_next.e = pattern.e;
			SLOT_F:  seg_next.f = pattern.f;
			SLOT_G:  seg_next.g = pattern.g;
			default: seg_next   = '1; // blank slot
		endcase
	end

	// outputs follow pos by one clock, dark until the controller is ready
	always_ff @(posedge CLK) begin
		if (reset || !ready) begin
			seg   <= '1;
			anode <= '0;
		end else begin
			seg   <= seg_next;
			anode <= anode_next;
		end
	end

endmodule

//--- hdl/seg_display_top.sv
/* top level of the seven-segment scan driver:
   controller, decimal counter, decoder and scanner */
`timescale 1ns/1ps
`include "seg_defines.svh"

module seg_display_top (
	input  logic                   CLK,
	input  logic                   reset,
	input  logic                   run,   // level, lets the count advance
	input  logic                   clear, // pulse, zeroes the count
	output seg_pkg::seg_pattern_t  seg,
	output logic [`SEG_DIGITS-1:0] anode,
	output seg_pkg::bcd_count_t    count,
	output logic                   ready
);
	import seg_pkg::*;

	scan_strobe_t strobe;      // slot and count ticks
	scan_pos_t    pos;         // digit and slot under the scan
	seg_pattern_t pattern;     // decoded digit at pos
	logic         frame_start; // scan back at digit 0, slot a

	scan_ctrl u_scan_ctrl (
		.CLK         (CLK),
		.reset       (reset),
		.frame_start (frame_start),
		.run         (run),
		.strobe      (strobe),
		.ready       (ready)
	);

	digit_counter u_digit_counter (
		.CLK        (CLK),
		.reset      (reset),
		.clear      (clear),
		.count_tick (strobe.count_tick),
		.count      (count)
	);

	seg_decoder u_seg_decoder (
		.CLK         (CLK),
		.reset       (reset),
		.frame_start (frame_start),
		.count       (count),
		.pos         (pos),
		.pattern     (pattern)
	);

	segment_scanner u_segment_scanner (
		.CLK         (CLK),
		.reset       (reset),
		.ready       (ready),
		.slot_tick   (strobe.slot_tick),
		.pattern     (pattern),
		.pos         (pos),
		.frame_start (frame_start),
		.seg         (seg),
		.anode       (anode)
	);

endmodule

//--- testbench/seg_display_asserts.sv
/* concurrent checks on the scanner outputs, bound into segment_scanner */
`timescale 1ns/1ps
`include "seg_defines.svh"

module seg_display_asserts (
	input logic                   CLK,
	input logic                   reset,
	input logic                   ready,
	input seg_pkg::seg_pattern_t  seg,
	input logic [`SEG_DIGITS-1:0] anode
);
	import seg_pkg::*;

	logic [6:0] seg_bits; // plain vector view, a is msb

	assign seg_bits = seg;

	// one segment lit at most
	a_one_segment: assert property (@(posedge CLK) disable iff (reset)
		$onehot0(~seg_bits))
		else $error("more than one segment lit");

	// one digit selected at most
	a_anode_onehot: assert property (@(posedge CLK) disable iff (reset)
		$onehot0(anode))
		else $error("anode not one-hot or zero");

	// dark display while the controller holds startup
	a_dark_startup: assert property (@(posedge CLK) disable iff (reset)
		!ready |-> (seg_bits == 7'h7f && anode == '0))
		else $error("display not dark while ready low");

endmodule

bind segment_scanner seg_display_asserts u_asserts (
	.CLK   (CLK),
	.reset (reset),
	.ready (ready),
	.seg   (seg),
	.anode (anode)
);

//--- testbench/seg_display_tb.sv
/* testbench for the seven-segment scan driver: clock, reset, directed tests,
   typed compare tasks, frame alignment helpers and watchdog */
`timescale 1ns/1ps
`include "seg_defines.svh"

module seg_display_tb;
	import seg_pkg::*;

	localparam int CLK_PERIOD  = 40;
	localparam int FRAME_CLKS  = 8 * `SEG_DIGITS * `DOT_DIV;                // clocks per scan frame
	localparam int TEST_FRAMES = 8 + 16 + 100 * `FRAMES_PER_COUNT + 16;      // rough frame budget
	localparam int WD_CYCLES   = 2 * (TEST_FRAMES * FRAME_CLKS + `STARTUP_CYCLES + 200);

	logic                   CLK;
	logic                   reset;
	logic                   run;
	logic                   clear;
	seg_pattern_t           seg;
	logic [`SEG_DIGITS-1:0] anode;
	bcd_count_t             count;
	logic                   ready;
	int                     errors;

	seg_display_top u_dut (
		.CLK   (CLK),
		.reset (reset),
		.run   (run),
		.clear (clear),
		.seg   (seg),
		.anode (anode),
		.count (count),
		.ready (ready)
	);

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_pattern(input string name, input seg_pattern_t got,
		input seg_pattern_t exp);
		if (got !== exp) begin
			errors++;
			fail_now($sformatf("** Error @ %0t: %s = %b, expected %b", $time, name, got, exp));
		end
	endtask

	task automatic check_count(input string name, input bcd_count_t got, input bcd_count_t exp);
		if (got !== exp) begin
			errors++;
			fail_now($sformatf("** Error @ %0t: %s = %h, expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			fail_now($sformatf("** Error @ %0t: %s = %b, expected %b", $time, name, got, exp));
		end
	endtask

	// reference table, written as lit segments a..g then inverted
	function automatic seg_pattern_t ref_pattern(input logic [3:0] val);
		logic [6:0] lit;
		case (val)
			4'd0:    lit = 7'b1111110;
			4'd1:    lit = 7'b0110000;
			4'd2:    lit = 7'b1101101;
			4'd3:    lit = 7'b1111001;
			4'd4:    lit = 7'b0110011;
			4'd5:    lit = 7'b1011011;
			4'd6:    lit = 7'b1011111;
			4'd7:    lit = 7'b1110000;
			4'd8:    lit = 7'b1111111;
			4'd9:    lit = 7'b1111011;
			default: lit = 7'b0000000;
		endcase
		return seg_pattern_t'(~lit);
	endfunction

	function automatic bcd_count_t to_bcd(input int n);
		bcd_count_t r;
		for (int i = 0; i < `SEG_DIGITS; i++) begin
			r[i] = 4'(n % 10);
			n    = n / 10;
		end
		return r;
	endfunction

	task automatic drive_run(input logic v);
		@(posedge CLK);
		#2 run = v;
	endtask

	// one clock pulse, count must read zero right after the edge that saw it
	task automatic pulse_clear();
		@(posedge CLK);
		#2 clear = 1'b1;
		@(posedge CLK);
		#2 clear = 1'b0;
		check_count("count", count, '0);
	endtask

	// returns at the negedge of the first output clock of digit 0, slot a
	task automatic align_frame();
		logic last_on;
		last_on = 1'b0;
		for (int i = 0; i < 2 * FRAME_CLKS + 8; i++) begin
			@(negedge CLK);
			if (last_on && anode == `SEG_DIGITS'(1)) begin
				return;
			end
			last_on = anode[`SEG_DIGITS-1];
		end
		fail_now("scan never wrapped back to digit 0 within two frames");
	endtask

	// called at cycle 0 of a frame; checks every clock and the gathered digit patterns
	task automatic check_frame(input bcd_count_t shown);
		seg_pattern_t want;
		seg_pattern_t gathered;
		seg_pattern_t digit_ref; // table pattern of the scanned digit
		for (int d = 0; d < `SEG_DIGITS; d++) begin
			gathered  = '1;
			digit_ref = ref_pattern(shown[d]);
			for (int s = 0; s < 8; s++) begin
				for (int c = 0; c < `DOT_DIV; c++) begin
					if (d != 0 || s != 0 || c != 0) @(negedge CLK);
					for (int i = 0; i < `SEG_DIGITS; i++) begin
						check_bit($sformatf("anode[%0d]", i), anode[i], (i == d));
					end
					want = '1;
					if (s < 7) want[6-s] = digit_ref[6-s]; // only this slot's bit
					check_pattern("seg", seg, want);
					if (c == 0 && s < 7) gathered[6-s] = seg[6-s];
				end
			end
			check_pattern($sformatf("digit %0d pattern", d), gathered, digit_ref);
		end
	endtask

	task automatic wait_count(input bcd_count_t target, input int limit);
		for (int i = 0; i < limit; i++) begin
			@(negedge CLK);
			if (count == target) return;
		end
		fail_now($sformatf("count never reached %h", target));
	endtask

	task automatic wait_change(input int limit);
		bcd_count_t was;
		was = count;
		for (int i = 0; i < limit; i++) begin
			@(negedge CLK);
			if (count != was) return;
		end
		fail_now("count stopped advancing while run was high");
	endtask

	// edge 1 is the first with reset low, ready comes up on edge STARTUP_CYCLES + 1
	task automatic test_startup();
		for (int n = 1; n <= `STARTUP_CYCLES; n++) begin
			@(posedge CLK);
			#1;
			check_bit("ready", ready, 1'b0);
			check_pattern("seg", seg, '1);
			for (int i = 0; i < `SEG_DIGITS; i++) check_bit("anode", anode[i], 1'b0);
			check_count("count", count, '0);
		end
		@(posedge CLK);
		#1;
		check_bit("ready", ready, 1'b1);
	endtask

	task automatic test_scan_order();
		align_frame();
		check_frame('0);
	endtask

	task automatic test_decode_zero();
		drive_run(1'b1);
		wait_change(2 * `FRAMES_PER_COUNT * FRAME_CLKS); // nonzero count for the clear
		drive_run(1'b0);
		pulse_clear();
		align_frame();
		align_frame();
		check_frame('0);
	endtask

	task automatic test_counting();
		int         frames;
		bcd_count_t exp;
		frames = 4 + int'($urandom % 9);
		pulse_clear();
		align_frame();
		drive_run(1'b1);
		repeat (frames) align_frame();
		drive_run(1'b0);
		repeat (8) @(negedge CLK);
		// free-running frame phase may move the last step by one
		exp = to_bcd(frames / `FRAMES_PER_COUNT);
		for (int k = -1; k <= 1; k++) begin
			if (count == to_bcd(frames / `FRAMES_PER_COUNT + k)) begin
				exp = to_bcd(frames / `FRAMES_PER_COUNT + k);
			end
		end
		check_count("count", count, exp);
		align_frame();
		align_frame();
		check_frame(exp);
		check_count("count", count, exp); // run low, no more steps
	endtask

	task automatic test_clear_carry();
		int step;
		step = 2 * `FRAMES_PER_COUNT * FRAME_CLKS;
		pulse_clear();
		drive_run(1'b1);
		wait_count(to_bcd(9), 12 * step);
		wait_change(step);
		check_count("count", count, to_bcd(10));
		wait_count(to_bcd(99), 95 * step);
		wait_change(step);
		check_count("count", count, to_bcd(100));
		pulse_clear(); // run still high
		drive_run(1'b0);
	endtask

	initial begin
		repeat (WD_CYCLES) @(posedge CLK);
		fail_now("watchdog expired, simulation ran too long");
	end

	initial begin
		errors = 0;
		void'($urandom(32'h5598));
		reset  = 1'b1;
		run    = 1'b0;
		clear  = 1'b0;
		repeat (5) @(posedge CLK);
		#2 reset = 1'b0;
		test_startup();
		test_scan_order();
		test_decode_zero();
		test_counting();
		test_clear_carry();
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

//--- src.f
+incdir+hdl
hdl/seg_pkg.sv
hdl/scan_ctrl.sv
hdl/digit_counter.sv
hdl/seg_decoder.sv
hdl/segment_scanner.sv
hdl/seg_display_top.sv
testbench/seg_display_asserts.sv
testbench/seg_display_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the seven-segment driver testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module seg_display_tb -o seg_display_sim

out=$(./obj_dir/seg_display_sim)
echo "$out"

if echo "$out" | grep -q "=== PASS ==="; then
	exit 0
else
	exit 1
fi
